//--- source/cdb_consts.svh
`ifndef CDB_CONSTS_SVH
`define CDB_CONSTS_SVH

// functional units, one bus entry each
// index 0 is the multiplier, index 1 the ALU
`define NUM_FU 2

// ROB depth, 4-bit index
`define NUM_ROB 16

// physical register file size, 5-bit tag
`define NUM_PR 32

// datapath width
`define XLEN 64

`endif

//--- source/ooo_pkg.sv
`include "cdb_consts.svh"

package ooo_pkg;

  localparam int ROB_W  = $clog2(`NUM_ROB); // rob index width
  localparam int PR_W   = $clog2(`NUM_PR);  // physical tag width
  localparam int AREG_W = 5;                // architectural dest width

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_MUL  // only opcode routed to the multiplier
  } fu_op_e;

  typedef struct packed {
    fu_op_e              op;
    logic [`XLEN-1:0]    src_a;
    logic [`XLEN-1:0]    src_b;
    logic [PR_W-1:0]     t_idx;    // physical dest tag
    logic [ROB_W-1:0]    rob_idx;
    logic [AREG_W-1:0]   dest_idx; // architectural dest
  } issue_pkt_t;

  typedef struct packed {
    logic                taken;    // entry holds a finished result
    logic [PR_W-1:0]     t_idx;
    logic [ROB_W-1:0]    rob_idx;
    logic [AREG_W-1:0]   dest_idx;
    logic [`XLEN-1:0]    value;
  } cdb_entry_t;

  // age test against the rollback point, distances taken modulo rob size
  function automatic logic is_squashed(input logic [ROB_W-1:0] rob_idx,
                                       input logic [ROB_W-1:0] rollback_idx,
                                       input logic [ROB_W-1:0] rob_tail);
    logic [ROB_W-1:0] age_dist;
    logic [ROB_W-1:0] tail_dist;
    age_dist  = rob_idx - rollback_idx;  // wraps naturally
    tail_dist = rob_tail - rollback_idx;
    return age_dist <= tail_dist;        // inside the squashed window
  endfunction

endpackage

//--- source/fu_result_if.sv
`timescale 1ns/100ps
`include "cdb_consts.svh"

interface fu_result_if import ooo_pkg::*; ();

  logic               done;     // unit holds a live result
  logic [PR_W-1:0]    t_idx;
  logic [ROB_W-1:0]   rob_idx;
  logic [AREG_W-1:0]  dest_idx;
  logic [`XLEN-1:0]   value;
  logic               free;     // bus entry can take it this edge

  // execute unit side
  modport unit (
    output done, t_idx, rob_idx, dest_idx, value,
    input  free
  );

  // result bus side
  modport bus (
    input  done, t_idx, rob_idx, dest_idx, value,
    output free
  );

endinterface

//--- source/issue_decode.sv
`timescale 1ns/100ps

module issue_decode import ooo_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       issue_valid,
  input  issue_pkt_t issue_pkt,
  input  logic       alu_ready,
  input  logic       mul_ready,
  output logic       issue_ready,
  output logic       alu_valid,
  output logic       mul_valid,
  output issue_pkt_t fu_pkt,
  output logic       illegal_op
);

  logic sel_alu;  // opcode belongs to the alu
  logic sel_mul;  // opcode belongs to the multiplier
  logic illegal;  // opcode outside the enum

  // unit select from opcode
  always_comb begin
    sel_alu = 1'b0;
    sel_mul = 1'b0;
    illegal = 1'b0;
    case (issue_pkt.op)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: sel_alu = 1'b1;
      OP_MUL:  sel_mul = 1'b1;
      default: illegal = 1'b1; // swallowed below
    endcase
  end

  assign alu_valid = issue_valid && sel_alu; // valid only to the chosen unit
  assign mul_valid = issue_valid && sel_mul;
  assign fu_pkt    = issue_pkt;              // same payload to both

  // ready comes back from the target unit only
  always_comb begin
    if (sel_mul) begin
      issue_ready = mul_ready;
    end else if (sel_alu) begin
      issue_ready = alu_ready;
    end else begin
      issue_ready = 1'b1;  // bad opcode always accepted and dropped
    end
  end

  // sticky flag, set on any accepted bad opcode
  always_ff @(posedge clock) begin
    if (reset) begin
      illegal_op <= 1'b0;
    end else if (issue_valid && illegal) begin
      illegal_op <= 1'b1;
    end
  end

endmodule

//--- source/alu_execute.sv
`timescale 1ns/100ps
`include "cdb_consts.svh"

module alu_execute import ooo_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  input  logic             in_valid,
  input  issue_pkt_t       in_pkt,
  input  logic             rollback_en,
  input  logic [ROB_W-1:0] rollback_idx,
  input  logic [ROB_W-1:0] rob_tail,
  output logic             in_ready,
  fu_result_if.unit        res
);

  logic               hold_valid;  // hold register occupied
  logic [PR_W-1:0]    hold_tag;
  logic [ROB_W-1:0]   hold_rob;
  logic [AREG_W-1:0]  hold_dest;
  logic [`XLEN-1:0]   hold_value;
  logic [`XLEN-1:0]   alu_out;     // combinational result
  logic               squash;      // held op lies in the rollback window

  always_comb begin
    case (in_pkt.op)
      OP_ADD:  alu_out = in_pkt.src_a + in_pkt.src_b;
      OP_SUB:  alu_out = in_pkt.src_a - in_pkt.src_b;
      OP_AND:  alu_out = in_pkt.src_a & in_pkt.src_b;
      OP_OR:   alu_out = in_pkt.src_a | in_pkt.src_b;
      OP_XOR:  alu_out = in_pkt.src_a ^ in_pkt.src_b;
      default: alu_out = '0;  // never steered here
    endcase
  end

  assign squash   = rollback_en && hold_valid && is_squashed(hold_rob, rollback_idx, rob_tail);
  assign in_ready = !hold_valid || res.free;  // empty or being taken

  // done masked while squashing so the bus never latches a dead op
  assign res.done     = hold_valid && !squash;
  assign res.t_idx    = hold_tag;
  assign res.rob_idx  = hold_rob;
  assign res.dest_idx = hold_dest;
  assign res.value    = hold_value;

  always_ff @(posedge clock) begin
    if (reset) begin
      hold_valid <= 1'b0;
    end else if (in_valid && in_ready) begin
      hold_valid <= 1'b1;  // new op replaces the departing one
    end else if (squash || res.free) begin
      hold_valid <= 1'b0;  // taken or killed
    end
  end

  // payload, no reset
  always_ff @(posedge clock) begin
    if (in_valid && in_ready) begin
      hold_tag   <= in_pkt.t_idx;
      hold_rob   <= in_pkt.rob_idx;
      hold_dest  <= in_pkt.dest_idx;
      hold_value <= alu_out;
    end
  end

endmodule

//--- source/mult_execute.sv
`timescale 1ns/100ps
`include "cdb_consts.svh"

module mult_execute import ooo_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  input  logic             in_valid,
  input  issue_pkt_t       in_pkt,
  input  logic             rollback_en,
  input  logic [ROB_W-1:0] rollback_idx,
  input  logic [ROB_W-1:0] rob_tail,
  output logic             in_ready,
  fu_result_if.unit        res
);

  logic [2:0]              stg_valid;  // per stage occupancy
  logic [2:0]              stg_squash; // per stage rollback hit
  logic [2:0][PR_W-1:0]    stg_tag;
  logic [2:0][ROB_W-1:0]   stg_rob;
  logic [2:0][AREG_W-1:0]  stg_dest;
  logic [`XLEN-1:0]        s1_a;       // registered operands
  logic [`XLEN-1:0]        s1_b;
  logic [`XLEN-1:0]        s2_lo;      // a_lo * b_lo
  logic [`XLEN/2-1:0]      s2_cross;   // low half of the two cross terms
  logic [`XLEN-1:0]        s3_prod;    // final low product
  logic                    advance;    // whole pipe shifts

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      stg_squash[i] = rollback_en && stg_valid[i] &&
                      is_squashed(stg_rob[i], rollback_idx, rob_tail);
    end
  end

  assign advance  = !stg_valid[2] || res.free;  // last stage empty or taken
  assign in_ready = advance;

  assign res.done     = stg_valid[2] && !stg_squash[2];
  assign res.t_idx    = stg_tag[2];
  assign res.rob_idx  = stg_rob[2];
  assign res.dest_idx = stg_dest[2];
  assign res.value    = s3_prod;

  always_ff @(posedge clock) begin
    if (reset) begin
      stg_valid <= '0;
    end else if (advance) begin
      stg_valid[0] <= in_valid;                        // accepted this edge
      stg_valid[1] <= stg_valid[0] && !stg_squash[0];
      stg_valid[2] <= stg_valid[1] && !stg_squash[1];
    end else begin
      stg_valid <= stg_valid & ~stg_squash;            // frozen, kill in place
    end
  end

  // payload moves with the valids, no reset
  always_ff @(posedge clock) begin
    if (advance) begin
      stg_tag  <= {stg_tag[1:0], in_pkt.t_idx};
      stg_rob  <= {stg_rob[1:0], in_pkt.rob_idx};
      stg_dest <= {stg_dest[1:0], in_pkt.dest_idx};
      s1_a     <= in_pkt.src_a;
      s1_b     <= in_pkt.src_b;
      s2_lo    <= s1_a[31:0] * s1_b[31:0];
      s2_cross <= s1_a[31:0] * s1_b[63:32] + s1_a[63:32] * s1_b[31:0]; // upper bits drop
      s3_prod  <= s2_lo + {s2_cross, 32'b0};
    end
  end

endmodule

//--- source/cdb.sv
`timescale 1ns/100ps
`include "cdb_consts.svh"

module cdb import ooo_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  input  logic              rollback_en,
  input  logic [ROB_W-1:0]  rollback_idx,
  input  logic [ROB_W-1:0]  rob_tail,
  fu_result_if.bus          fu [`NUM_FU],
  output logic              complete_en,
  output logic [PR_W-1:0]   cdb_tag,
  output logic [ROB_W-1:0]  cdb_rob_idx,
  output logic [AREG_W-1:0] cdb_dest_idx,
  output logic [`XLEN-1:0]  cdb_value
);

  localparam int SEL_W = $clog2(`NUM_FU);

  cdb_entry_t [`NUM_FU-1:0] entry_q;   // one slot per unit
  cdb_entry_t [`NUM_FU-1:0] entry_d;
  cdb_entry_t [`NUM_FU-1:0] incoming;  // unit results as entries
  logic       [`NUM_FU-1:0] in_done;
  logic       [`NUM_FU-1:0] squash;    // entry inside the rollback window
  logic       [`NUM_FU-1:0] emptying;  // entry free for the next edge
  logic       [SEL_W-1:0]   sel;       // broadcast winner

  // unpack interface array, constant indices only
  for (genvar g = 0; g < `NUM_FU; g++) begin : g_port
    assign in_done[g]           = fu[g].done;
    assign incoming[g].taken    = 1'b1;
    assign incoming[g].t_idx    = fu[g].t_idx;
    assign incoming[g].rob_idx  = fu[g].rob_idx;
    assign incoming[g].dest_idx = fu[g].dest_idx;
    assign incoming[g].value    = fu[g].value;
    assign fu[g].free           = emptying[g];
  end

  always_comb begin
    for (int i = 0; i < `NUM_FU; i++) begin
      squash[i] = rollback_en && entry_q[i].taken &&
                  is_squashed(entry_q[i].rob_idx, rollback_idx, rob_tail);
    end
  end

  // fixed priority, lowest index wins
  always_comb begin
    complete_en = 1'b0;
    sel         = '0;
    for (int i = `NUM_FU - 1; i >= 0; i--) begin
      if (entry_q[i].taken && !squash[i]) begin
        complete_en = 1'b1;
        sel         = SEL_W'(i);
      end
    end
  end

  // broadcast, zeros when idle
  always_comb begin
    if (complete_en) begin
      cdb_tag      = entry_q[sel].t_idx;
      cdb_rob_idx  = entry_q[sel].rob_idx;
      cdb_dest_idx = entry_q[sel].dest_idx;
      cdb_value    = entry_q[sel].value;
    end else begin
      cdb_tag      = '0;
      cdb_rob_idx  = '0;
      cdb_dest_idx = '0;
      cdb_value    = '0;
    end
  end

  always_comb begin
    for (int i = 0; i < `NUM_FU; i++) begin
      emptying[i] = !entry_q[i].taken || squash[i] ||
                    (complete_en && sel == SEL_W'(i));
      if (!emptying[i]) begin
        entry_d[i] = entry_q[i];           // still waiting for the bus
      end else if (in_done[i]) begin
        entry_d[i] = incoming[i];          // refill in the same edge
      end else begin
        entry_d[i]       = entry_q[i];
        entry_d[i].taken = 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      entry_q <= '0;
    end else begin
      entry_q <= entry_d;
    end
  end

endmodule

//--- source/completion_core.sv
`timescale 1ns/100ps
`include "cdb_consts.svh"

module completion_core import ooo_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  input  logic              issue_valid,
  input  logic [2:0]        issue_op,
  input  logic [`XLEN-1:0]  issue_src_a,
  input  logic [`XLEN-1:0]  issue_src_b,
  input  logic [PR_W-1:0]   issue_tag,
  input  logic [ROB_W-1:0]  issue_rob_idx,
  input  logic [AREG_W-1:0] issue_dest_idx,
  input  logic              rollback_en,
  input  logic [ROB_W-1:0]  rollback_idx,
  input  logic [ROB_W-1:0]  rob_tail,
  output logic              issue_ready,
  output logic              illegal_op,
  output logic              complete_en,
  output logic [PR_W-1:0]   cdb_tag,
  output logic [ROB_W-1:0]  cdb_rob_idx,
  output logic [AREG_W-1:0] cdb_dest_idx,
  output logic [`XLEN-1:0]  cdb_value
);

  issue_pkt_t issue_pkt;  // packed issue port
  issue_pkt_t fu_pkt;     // steered copy
  logic       alu_valid;
  logic       alu_ready;
  logic       mul_valid;
  logic       mul_ready;

  // slot 0 multiplier, slot 1 alu
  fu_result_if fu_bus [`NUM_FU] ();

  assign issue_pkt = '{op:       fu_op_e'(issue_op),  // raw bits, bad codes kept
                       src_a:    issue_src_a,
                       src_b:    issue_src_b,
                       t_idx:    issue_tag,
                       rob_idx:  issue_rob_idx,
                       dest_idx: issue_dest_idx};

  issue_decode u_decode (
    .clock, .reset, .issue_valid, .issue_pkt, .alu_ready, .mul_ready,
    .issue_ready, .alu_valid, .mul_valid, .fu_pkt, .illegal_op
  );

  mult_execute u_mult (
    .clock, .reset, .in_valid(mul_valid), .in_pkt(fu_pkt),
    .rollback_en, .rollback_idx, .rob_tail, .in_ready(mul_ready), .res(fu_bus[0])
  );

  alu_execute u_alu (
    .clock, .reset, .in_valid(alu_valid), .in_pkt(fu_pkt),
    .rollback_en, .rollback_idx, .rob_tail, .in_ready(alu_ready), .res(fu_bus[1])
  );

  cdb u_cdb (
    .clock, .reset, .rollback_en, .rollback_idx, .rob_tail, .fu(fu_bus),
    .complete_en, .cdb_tag, .cdb_rob_idx, .cdb_dest_idx, .cdb_value
  );

endmodule

//--- tests/tb_completion_core.sv
`timescale 1ns/100ps
`include "cdb_consts.svh"

module tb_completion_core import ooo_pkg::*; ();

  logic                clock;
  logic                reset;
  logic                issue_valid;
  logic [2:0]          issue_op;
  logic [`XLEN-1:0]    issue_src_a;
  logic [`XLEN-1:0]    issue_src_b;
  logic [PR_W-1:0]     issue_tag;
  logic [ROB_W-1:0]    issue_rob_idx;
  logic [AREG_W-1:0]   issue_dest_idx;
  logic                rollback_en;
  logic [ROB_W-1:0]    rollback_idx;
  logic [ROB_W-1:0]    rob_tail;
  logic                issue_ready;
  logic                illegal_op;
  logic                complete_en;
  logic [PR_W-1:0]     cdb_tag;
  logic [ROB_W-1:0]    cdb_rob_idx;
  logic [AREG_W-1:0]   cdb_dest_idx;
  logic [`XLEN-1:0]    cdb_value;

  bit                  live [`NUM_ROB];     // rob slots in flight
  logic [PR_W-1:0]     exp_tag [`NUM_ROB];
  logic [AREG_W-1:0]   exp_dest [`NUM_ROB];
  logic [`XLEN-1:0]    exp_value [`NUM_ROB];
  logic [ROB_W-1:0]    next_rob;            // tb plays the rob allocator
  logic [31:0]         rng_state;
  logic [31:0]         r;
  int                  errors;
  int                  err_base;
  int                  tests_run;
  int                  tests_failed;
  int                  accepted;
  int                  completions;
  int                  squashed;
  string               cur_test;

  completion_core dut (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;  // 8 ns period
  end

  function automatic logic [31:0] xorshift_next();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // reference result, 64-bit wraparound
  function automatic logic [`XLEN-1:0] expected_result(input logic [2:0] op,
                                                       input logic [`XLEN-1:0] a,
                                                       input logic [`XLEN-1:0] b);
    case (fu_op_e'(op))
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      default: return a * b;  // low half of the product
    endcase
  endfunction

  // younger than or equal to the rollback point, up to the tail
  function automatic bit in_window(input int idx, input int rb, input int tail);
    int idx_dist;
    int tail_dist;
    idx_dist  = (idx - rb + `NUM_ROB) % `NUM_ROB;
    tail_dist = (tail - rb + `NUM_ROB) % `NUM_ROB;
    return idx_dist <= tail_dist;
  endfunction

  function automatic int live_count();
    int n;
    n = 0;
    foreach (live[i]) begin
      n += live[i];
    end
    return n;
  endfunction

  // scoreboard, sampled mid cycle
  always @(negedge clock) begin
    if (!reset) begin
      if (complete_en) begin
        completions++;  // every broadcast, live or not
        assert (live[cdb_rob_idx]) else begin
          errors++;
          $display("%s: completion for rob %0d, which is not in flight", cur_test, cdb_rob_idx);
        end
        assert (!(rollback_en && in_window(cdb_rob_idx, rollback_idx, rob_tail))) else begin
          errors++;
          $display("%s: rob %0d completed while being rolled back", cur_test, cdb_rob_idx);
        end
        if (live[cdb_rob_idx]) begin
          assert (cdb_value == exp_value[cdb_rob_idx]) else begin
            errors++;
            $display("mismatch %s rob %0d value expected %h actual %h", cur_test,
                     cdb_rob_idx, exp_value[cdb_rob_idx], cdb_value);
          end
          assert (cdb_tag == exp_tag[cdb_rob_idx]) else begin
            errors++;
            $display("mismatch %s rob %0d tag expected %0d actual %0d", cur_test,
                     cdb_rob_idx, exp_tag[cdb_rob_idx], cdb_tag);
          end
          assert (cdb_dest_idx == exp_dest[cdb_rob_idx]) else begin
            errors++;
            $display("mismatch %s rob %0d dest expected %0d actual %0d", cur_test,
                     cdb_rob_idx, exp_dest[cdb_rob_idx], cdb_dest_idx);
          end
          live[cdb_rob_idx] = 1'b0;
        end
      end
      if (rollback_en) begin
        foreach (live[i]) begin
          if (live[i] && in_window(i, rollback_idx, rob_tail)) begin
            live[i] = 1'b0;  // must never complete now
            squashed++;
          end
        end
      end
      if (issue_valid && issue_ready && issue_op <= 3'(OP_MUL)) begin  // bad codes leave no entry
        live[issue_rob_idx]      = 1'b1;
        exp_tag[issue_rob_idx]   = issue_tag;
        exp_dest[issue_rob_idx]  = issue_dest_idx;
        exp_value[issue_rob_idx] = expected_result(issue_op, issue_src_a, issue_src_b);
        accepted++;
      end
    end
  end

  // same rob index never broadcast on two cycles in a row
  no_double_complete: assert property (@(negedge clock) disable iff (reset)
    !(complete_en && $past(complete_en) && cdb_rob_idx == $past(cdb_rob_idx)))
    else begin
      errors++;
      $display("%s: rob %0d completed in two cycles in a row", cur_test, cdb_rob_idx);
    end

  // called and returns 1 ns after a rising edge
  task automatic send_packet(input logic [2:0] op);
    int waited;
    logic [31:0] pick;
    waited = 0;
    while (live[next_rob] && waited < 100) begin  // slot still owned by an older op
      @(posedge clock);
      #1;
      waited++;
    end
    if (live[next_rob]) begin
      errors++;
      $display("%s: timeout, rob slot %0d was never freed", cur_test, next_rob);
    end
    pick           = xorshift_next();
    issue_valid    = 1'b1;
    issue_op       = op;
    issue_src_a    = {xorshift_next(), xorshift_next()};
    issue_src_b    = {xorshift_next(), xorshift_next()};
    issue_tag      = pick[4:0];
    issue_dest_idx = pick[9:5];
    issue_rob_idx  = next_rob;
    waited = 0;
    @(negedge clock);
    while (!issue_ready && waited < 100) begin  // valid held until ready
      @(negedge clock);
      waited++;
    end
    if (!issue_ready) begin
      errors++;
      $display("%s: timeout, issue_ready stayed low for 100 cycles", cur_test);
    end
    @(posedge clock);
    #1;
    issue_valid = 1'b0;
    next_rob++;
  endtask

  task automatic pulse_rollback(input logic [ROB_W-1:0] depth);
    rollback_idx = next_rob - depth;
    rob_tail     = next_rob - 1'b1;  // newest allocated slot
    rollback_en  = 1'b1;
    @(posedge clock);
    #1;
    rollback_en = 1'b0;
    next_rob    = rollback_idx;      // rob tail moves back
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (live_count() != 0 && waited < 300) begin
      @(posedge clock);
      #1;
      waited++;
    end
    if (live_count() != 0) begin
      errors++;
      $display("%s: timeout, %0d packets never completed", cur_test, live_count());
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    err_base = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != err_base) begin
      tests_failed++;
    end
    $display("test %s %s, %0d errors", cur_test, (errors == err_base) ? "ok" : "failed",
             errors - err_base);
  endtask

  initial begin
    int acc0;
    int done0;
    reset = 1'b1;
    issue_valid = 1'b0;
    issue_op = 3'd0;
    issue_src_a = '0;
    issue_src_b = '0;
    issue_tag = '0;
    issue_rob_idx = '0;
    issue_dest_idx = '0;
    rollback_en = 1'b0;
    rollback_idx = '0;
    rob_tail = '0;
    next_rob = '0;
    rng_state = 32'hee78;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    accepted = 0;
    completions = 0;
    squashed = 0;
    cur_test = "reset";
    foreach (live[i]) begin
      live[i] = 1'b0;
    end
    repeat (8) @(posedge clock);
    #1;
    reset = 1'b0;

    start_test("reset");
    repeat (6) begin
      @(negedge clock);
      assert (!complete_en) else begin
        errors++;
        $display("mismatch reset complete_en expected 0 actual %b", complete_en);
      end
      assert (issue_ready) else begin
        errors++;
        $display("mismatch reset issue_ready expected 1 actual %b", issue_ready);
      end
      assert (!illegal_op) else begin
        errors++;
        $display("mismatch reset illegal_op expected 0 actual %b", illegal_op);
      end
    end
    @(posedge clock);
    #1;
    end_test();

    start_test("arithmetic");
    repeat (200) begin
      r = xorshift_next();
      send_packet(3'(r % 6));
    end
    drain();
    end_test();

    start_test("exactly_once");
    acc0  = accepted;
    done0 = completions + squashed;
    repeat (40) begin
      r = xorshift_next();
      send_packet(3'(r % 6));
      repeat (r[9:8]) begin  // idle gap of 0 to 3 cycles
        @(posedge clock);
        #1;
      end
    end
    drain();
    assert (completions + squashed - done0 == accepted - acc0) else begin
      errors++;
      $display("mismatch exactly_once count expected %0d actual %0d", accepted - acc0,
               completions + squashed - done0);
    end
    end_test();

    start_test("backpressure");
    for (int i = 0; i < 30; i++) begin
      r = xorshift_next();
      send_packet((i % 5 < 2) ? 3'(OP_MUL) : 3'(r % 5));  // two multiplies, then three alu ops
    end
    drain();
    end_test();

    start_test("rollback");
    repeat (4) begin
      repeat (6) begin
        r = xorshift_next();
        send_packet(3'(r % 6));
      end
      r = xorshift_next();
      pulse_rollback(ROB_W'(r % 3 + 1));  // drop the last one to three
    end
    drain();
    end_test();

    start_test("illegal");
    send_packet(3'd6);
    send_packet(3'd7);
    assert (illegal_op) else begin
      errors++;
      $display("mismatch illegal illegal_op expected 1 actual %b", illegal_op);
    end
    repeat (12) begin  // window for a stray completion
      @(posedge clock);
      #1;
    end
    end_test();

    $display("tests %0d, failed %0d, errors %0d, completions %0d, squashed %0d",
             tests_run, tests_failed, errors, completions, squashed);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- completion_core.f
+incdir+source
source/ooo_pkg.sv
source/fu_result_if.sv
source/issue_decode.sv
source/alu_execute.sv
source/mult_execute.sv
source/cdb.sv
source/completion_core.sv
tests/tb_completion_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_completion_core \
  -f completion_core.f -Mdir obj_dir

output=$(./obj_dir/Vtb_completion_core)
echo "$output"
if echo "$output" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1
